/* Makefile */
VERILATOR  ?= verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_top
RTL_TOP    = cache_dram_fill
FILELIST   = sim.f
OBJ_DIR    = obj_dir
PASS_MSG   = >>> PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* sim.f */
src/cache_pkg.sv
src/fill_fifo.sv
src/dram_fill_queue.sv
src/dram_req_issuer.sv
src/cache_dram_fill.sv
verification/fill_checker.sv
verification/tb_top.sv

/* src/cache_dram_fill.sv */
`timescale 1ns/1ps

module cache_dram_fill (
	input  logic                 clk,
	input  logic                 reset,

	// bank side
	input  logic                 fill_push,
	input  cache_pkg::fill_vec_t fill_vec,
	output logic                 fill_full,

	// dram side
	output logic                 dram_req_valid,
	output cache_pkg::dram_req_t dram_req,
	input  logic                 dram_ready,
	input  logic                 dram_rsp_valid
);
	import cache_pkg::*;

	logic      q_req_valid;
	logic      q_take;
	dram_req_t q_req;  // next request in bank order

	// **********************************************************************
	// request queue
	// **********************************************************************

	dram_fill_queue u_dram_fill_queue (
		.clk         (clk),
		.reset       (reset),
		.fill_push   (fill_push),
		.fill_vec    (fill_vec),
		.fill_full   (fill_full),
		.q_take      (q_take),
		.q_req_valid (q_req_valid),
		.q_req       (q_req)
	);

	// **********************************************************************
	// issuer toward dram
	// **********************************************************************

	dram_req_issuer u_dram_req_issuer (
		.clk            (clk),
		.reset          (reset),
		.q_req_valid    (q_req_valid),
		.q_req          (q_req),
		.q_take         (q_take),
		.dram_req_valid (dram_req_valid),
		.dram_req       (dram_req),
		.dram_ready     (dram_ready),
		.dram_rsp_valid (dram_rsp_valid)
	);

endmodule

/* src/cache_pkg.sv */
package cache_pkg;

	// **********************************************************************
	// sizes
	// **********************************************************************

	localparam int NUM_BANKS       = 4;
	localparam int BANK_IDX_W      = 2;   // index of one bank
	localparam int ADDR_W          = 32;  // cache line address
	localparam int DFQ_DEPTH       = 4;   // request vectors held in the fill fifo
	localparam int MAX_OUTSTANDING = 4;   // dram requests in flight

	localparam int FIFO_PTR_W = (DFQ_DEPTH > 1) ? $clog2(DFQ_DEPTH) : 1;
	localparam int FIFO_CNT_W = $clog2(DFQ_DEPTH + 1);
	localparam int CREDIT_W   = $clog2(MAX_OUTSTANDING + 1);

	// **********************************************************************
	// request types
	// **********************************************************************

	// one fill request per bank, pushed together in a single cycle
	typedef struct packed {
		logic [NUM_BANKS-1:0]             valid;
		logic [NUM_BANKS-1:0][ADDR_W-1:0] addr;
	} fill_vec_t;

	// single request toward dram, tagged with the bank that missed
	typedef struct packed {
		logic [ADDR_W-1:0]     addr;
		logic [BANK_IDX_W-1:0] bank;
	} dram_req_t;

	// issuer output register
	typedef enum logic {
		IDLE,  // register empty
		HOLD   // request waiting for dram_ready
	} issue_state_t;

endpackage

/* src/dram_fill_queue.sv */
`timescale 1ns/1ps

module dram_fill_queue (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 fill_push,
	input  cache_pkg::fill_vec_t fill_vec,
	output logic                 fill_full,
	input  logic                 q_take,
	output logic                 q_req_valid,
	output cache_pkg::dram_req_t q_req
);
	import cache_pkg::*;

	fill_vec_t                        head;
	logic                             fifo_empty;
	logic                             fifo_push;
	logic                             fifo_pop;

	logic [NUM_BANKS-1:0]             work_valid;  // banks of current vector still pending
	logic [NUM_BANKS-1:0][ADDR_W-1:0] work_addr;
	logic                             work_empty;

	logic [NUM_BANKS-1:0]             sel_valid;
	logic [NUM_BANKS-1:0][ADDR_W-1:0] sel_addr;
	logic [BANK_IDX_W-1:0]            sel_idx;
	logic                             take;

	assign fifo_push = fill_push && (|fill_vec.valid);  // empty vectors never enter

	fill_fifo u_fill_fifo (
		.clk      (clk),
		.reset    (reset),
		.push     (fifo_push),
		.in_data  (fill_vec),
		.pop      (fifo_pop),
		.out_data (head),
		.empty    (fifo_empty),
		.full     (fill_full)
	);

	// **********************************************************************
	// request selection
	// **********************************************************************

	assign work_empty = !(|work_valid);

	always_comb begin
		if (work_empty) begin
			sel_valid = fifo_empty ? '0 : head.valid;  // fresh vector from the fifo head
			sel_addr  = head.addr;
		end else begin
			sel_valid = work_valid;
			sel_addr  = work_addr;
		end
	end

	// lowest bank index wins
	always_comb begin
		sel_idx = '0;
		for (int i = NUM_BANKS - 1; i >= 0; i--) begin
			if (sel_valid[i]) begin
				sel_idx = BANK_IDX_W'(i);
			end
		end
	end

	assign q_req_valid = |sel_valid;
	assign q_req.addr  = sel_addr[sel_idx];
	assign q_req.bank  = sel_idx;

	assign take     = q_take && q_req_valid;
	assign fifo_pop = take && work_empty;  // head leaves on its first take

	always_ff @(posedge clk) begin
		if (reset) begin
			work_valid <= '0;
		end else if (take) begin
			work_valid <= sel_valid & ~(NUM_BANKS'(1) << sel_idx);
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			work_addr <= sel_addr;
		end
	end

	// **********************************************************************
	// checks
	// **********************************************************************

	a_no_push_full: assert property (@(posedge clk) disable iff (reset)
		!(fill_push && fill_full))
		else $error("fill request vector lost, queue full");

	// an offered request stays put until the issuer takes it
	a_req_hold: assert property (@(posedge clk) disable iff (reset)
		(q_req_valid && !q_take) |=> (q_req_valid && $stable(q_req)))
		else $error("queued request changed before take");

endmodule

/* src/dram_req_issuer.sv */
`timescale 1ns/1ps

module dram_req_issuer (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 q_req_valid,
	input  cache_pkg::dram_req_t q_req,
	output logic                 q_take,
	output logic                 dram_req_valid,
	output cache_pkg::dram_req_t dram_req,
	input  logic                 dram_ready,
	input  logic                 dram_rsp_valid
);
	import cache_pkg::*;

	issue_state_t        state;
	issue_state_t        state_nxt;
	dram_req_t           out_reg;
	logic [CREDIT_W-1:0] credits;  // free slots for requests in flight
	logic                credit_free;
	logic                take;

	assign credit_free = (credits != '0);
	assign q_take      = credit_free && ((state == IDLE) || dram_ready);
	assign take        = q_take && q_req_valid;

	assign dram_req_valid = (state == HOLD);
	assign dram_req       = out_reg;

	// **********************************************************************
	// output register
	// **********************************************************************

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (take) begin
					state_nxt = HOLD;
				end
			end
			HOLD: begin
				if (dram_ready && !take) begin
					state_nxt = IDLE;  // accepted, nothing behind it
				end
			end
			default: begin
				state_nxt = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out_reg <= q_req;
		end
	end

	// **********************************************************************
	// credits
	// **********************************************************************

	always_ff @(posedge clk) begin
		if (reset) begin
			credits <= CREDIT_W'(MAX_OUTSTANDING);
		end else begin
			case ({take, dram_rsp_valid})
				2'b10: begin
					credits <= credits - 1'b1;
				end
				2'b01: begin
					credits <= credits + 1'b1;  // response frees a slot
				end
				default: begin
					credits <= credits;
				end
			endcase
		end
	end

	a_credit_bound: assert property (@(posedge clk) disable iff (reset)
		credits <= CREDIT_W'(MAX_OUTSTANDING))
		else $error("more responses than requests in flight");

	a_req_stable: assert property (@(posedge clk) disable iff (reset)
		(dram_req_valid && !dram_ready) |=> (dram_req_valid && $stable(dram_req)))
		else $error("dram request changed while stalled");

endmodule

/* src/fill_fifo.sv */
`timescale 1ns/1ps

module fill_fifo (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 push,
	input  cache_pkg::fill_vec_t in_data,
	input  logic                 pop,
	output cache_pkg::fill_vec_t out_data,
	output logic                 empty,
	output logic                 full
);
	import cache_pkg::*;

	fill_vec_t             mem [DFQ_DEPTH];
	logic [FIFO_PTR_W-1:0] rd_ptr;
	logic [FIFO_PTR_W-1:0] wr_ptr;
	logic [FIFO_CNT_W-1:0] count;
	logic                  push_ok;
	logic                  pop_ok;

	function automatic logic [FIFO_PTR_W-1:0] ptr_inc(input logic [FIFO_PTR_W-1:0] ptr);
		if (ptr == FIFO_PTR_W'(DFQ_DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign push_ok = push && !full;  // dropped when full
	assign pop_ok  = pop && !empty;

	assign empty    = (count == '0);
	assign full     = (count == FIFO_CNT_W'(DFQ_DEPTH));
	assign out_data = mem[rd_ptr];  // first word falls through

	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (pop_ok) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			case ({push_ok, pop_ok})
				2'b10: begin
					count <= count + 1'b1;
				end
				2'b01: begin
					count <= count - 1'b1;
				end
				default: begin
					count <= count;
				end
			endcase
		end
	end

	// **********************************************************************
	// checks
	// **********************************************************************

	a_count_bound: assert property (@(posedge clk) disable iff (reset)
		count <= FIFO_CNT_W'(DFQ_DEPTH))
		else $error("fill_fifo count above depth");

endmodule

/* verification/fill_checker.sv */
`timescale 1ns/1ps

module fill_checker (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 fill_push,
	input  cache_pkg::fill_vec_t fill_vec,
	input  logic                 fill_full,
	input  logic                 dram_req_valid,
	input  cache_pkg::dram_req_t dram_req,
	input  logic                 dram_ready,
	input  logic                 dram_rsp_valid,
	input  logic                 end_check,
	output int                   mismatch_count,
	output int                   error_count,
	output int                   in_flight
);
	import cache_pkg::*;

	dram_req_t model_q [$];  // expected requests in issue order
	dram_req_t expected;
	dram_req_t held_req;
	logic      was_stalled = 1'b0;
	logic      reset_d = 1'b0;
	int        accepted = 0;
	int        responses = 0;

	initial begin
		mismatch_count = 0;
		error_count    = 0;
		in_flight      = 0;
	end

	always @(posedge clk) begin
		if (reset) begin
			model_q.delete();
			accepted    = 0;
			responses   = 0;
			was_stalled = 1'b0;
			reset_d     = 1'b1;
		end else begin
			if (reset_d && (fill_full !== 1'b0 || dram_req_valid !== 1'b0)) begin
				$display("CHECK FAILED at %0t: fill_full=%b dram_req_valid=%b after reset",
					$time, fill_full, dram_req_valid);
				mismatch_count++;
			end
			reset_d = 1'b0;

			// **************************************************************
			// model of the bank side
			// **************************************************************
			if (fill_push) begin
				for (int i = 0; i < NUM_BANKS; i++) begin
					if (fill_vec.valid[i]) begin  // lowest bank first
						expected.addr = fill_vec.addr[i];
						expected.bank = BANK_IDX_W'(i);
						model_q.push_back(expected);
					end
				end
			end

			if (dram_rsp_valid) begin
				responses++;
			end

			if (dram_req_valid && dram_ready) begin
				accepted++;
				if (model_q.size() == 0) begin
					$display("error at %0t: DRAM request 0x%h bank %0d was never expected",
						$time, dram_req.addr, dram_req.bank);
					error_count++;
				end else begin
					expected = model_q.pop_front();
					if (dram_req !== expected) begin
						$display("CHECK FAILED at %0t: got addr 0x%h bank %0d, expected 0x%h bank %0d",
							$time, dram_req.addr, dram_req.bank, expected.addr, expected.bank);
						mismatch_count++;
					end
				end
				if (accepted - responses > MAX_OUTSTANDING) begin
					$display("error at %0t: %0d DRAM requests outstanding", $time,
						accepted - responses);
					error_count++;
				end
			end

			if (was_stalled && (dram_req_valid !== 1'b1 || dram_req !== held_req)) begin
				$display("CHECK FAILED at %0t: stalled DRAM request changed or dropped", $time);
				mismatch_count++;
			end
			was_stalled = dram_req_valid && !dram_ready;
			held_req    = dram_req;

			if (end_check) begin
				if (model_q.size() != 0) begin
					$display("error at end: %0d expected requests never issued", model_q.size());
					error_count++;
				end
			end
		end
		in_flight = accepted - responses;
	end

endmodule

/* verification/tb_top.sv */
`timescale 1ns/1ps

module tb_top;
	import cache_pkg::*;

	localparam int NUM_PUSHES     = 400;
	localparam int TIMEOUT_CYCLES = NUM_PUSHES * 20;
	localparam int RESET_CYCLES   = 8;

	logic        clk            = 1'b0;
	logic        reset          = 1'b1;
	logic        fill_push      = 1'b0;
	fill_vec_t   fill_vec       = '0;
	logic        dram_ready     = 1'b0;
	logic        dram_rsp_valid = 1'b0;
	logic        end_check      = 1'b0;
	logic        fill_full;
	logic        dram_req_valid;
	dram_req_t   dram_req;

	int          mismatch_count;
	int          error_count;
	int          in_flight;
	int          quiet_cycles = 0;  // cycles with the issuer idle and every credit back
	int          cycle_count = 0;
	int          pushes_done = 0;
	int          rsp_due [$];  // response cycle of each accepted request
	logic [31:0] lcg_state = 32'd16231;

	always #50 clk = ~clk;

	cache_dram_fill u_cache_dram_fill (
		.clk            (clk),
		.reset          (reset),
		.fill_push      (fill_push),
		.fill_vec       (fill_vec),
		.fill_full      (fill_full),
		.dram_req_valid (dram_req_valid),
		.dram_req       (dram_req),
		.dram_ready     (dram_ready),
		.dram_rsp_valid (dram_rsp_valid)
	);

	fill_checker u_fill_checker (
		.clk            (clk),
		.reset          (reset),
		.fill_push      (fill_push),
		.fill_vec       (fill_vec),
		.fill_full      (fill_full),
		.dram_req_valid (dram_req_valid),
		.dram_req       (dram_req),
		.dram_ready     (dram_ready),
		.dram_rsp_valid (dram_rsp_valid),
		.end_check      (end_check),
		.mismatch_count (mismatch_count),
		.error_count    (error_count),
		.in_flight      (in_flight)
	);

	function automatic logic [15:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[31:16];  // upper half of the state
	endfunction

	function automatic fill_vec_t random_vector();
		fill_vec_t v;
		v.valid = ((next_random() % 8) == 0) ? '0 : NUM_BANKS'(next_random());
		for (int i = 0; i < NUM_BANKS; i++) begin
			v.addr[i] = {next_random(), next_random()};
		end
		return v;
	endfunction

	// **********************************************************************
	// bank and dram stimulus on the falling edge
	// **********************************************************************

	always @(negedge clk) begin
		reset = (cycle_count < RESET_CYCLES);
		if (reset) begin
			fill_push      = 1'b0;
			fill_vec       = '0;
			dram_ready     = 1'b0;
			dram_rsp_valid = 1'b0;
		end else begin
			dram_ready     = ((next_random() % 10) < 6);  // ready ~60% of cycles
			dram_rsp_valid = 1'b0;
			if (rsp_due.size() != 0 && rsp_due[0] <= cycle_count) begin
				void'(rsp_due.pop_front());
				dram_rsp_valid = 1'b1;
			end
			fill_push = 1'b0;
			if (pushes_done < NUM_PUSHES && !fill_full && ((next_random() % 3) == 0)) begin
				fill_push   = 1'b1;
				fill_vec    = random_vector();
				pushes_done = pushes_done + 1;
			end
		end
	end

	// dram side acceptance and cycle limit
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (!reset && dram_req_valid && dram_ready) begin
			rsp_due.push_back(cycle_count + 1 + int'(next_random() % 8));
		end
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, fill path stopped making progress", cycle_count);
			$display("mismatches: %0d, other errors: %0d", mismatch_count, error_count + 1);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial begin
		wait (pushes_done == NUM_PUSHES);
		repeat (2) @(negedge clk);
		// a pending request would be taken and shown within one cycle
		while (quiet_cycles < 2) begin
			@(negedge clk);
			if (dram_req_valid || in_flight != 0) begin
				quiet_cycles = 0;
			end else begin
				quiet_cycles = quiet_cycles + 1;
			end
		end
		end_check = 1'b1;
		@(negedge clk);
		end_check = 1'b0;
		@(negedge clk);
		$display("mismatches: %0d, other errors: %0d", mismatch_count, error_count);
		if (mismatch_count == 0 && error_count == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule
